// File: bench/pipe_testdata.txt
// columns: instruction, commit_we, commit_rd, commit_wdata, commit_ale
// wdata only matters when commit_we is 1; row n runs at pc 0x1000 + 4*n
// alu ops with back-to-back register hazards
1C001401 1 01 00000005 0
1C3FF402 1 02 FFFFFFFD 0
00000823 1 03 00000002 0
04000824 1 04 00000008 0
0C000485 1 05 0000000D 0
100008A6 1 06 FFFFFFF0 0
080008C7 1 07 FFFFFFF0 0
14000828 1 08 00000001 0
14000449 1 09 00000000 0
1800102A 1 0A 00000050 0
// mul stalls younger instructions
1C1FFC0B 1 0B 000007FF 0
2000096C 1 0C FFFFE803 0
1C00042D 1 0D 00000006 0
2000318E 1 0E 023F7009 0
040035CF 1 0F 023F7003 0
// stores merged by lane, then loads
1C040010 1 10 00000100 0
6800020E 0 0E 00000000 0
60000601 0 01 00000000 0
64000A0D 0 0D 00000000 0
50000212 1 12 00060509 0
6800120C 0 0C 00000000 0
64001A01 0 01 00000000 0
40001613 1 13 FFFFFFE8 0
44001614 1 14 000000E8 0
48001215 1 15 FFFFE803 0
4C001216 1 16 0000E803 0
48001A17 1 17 00000005 0
50001218 1 18 0005E803 0
00005279 1 19 000000D0 0
// misaligned accesses leave memory unchanged
5000061A 0 1A 00000000 1
68000A01 0 01 00000000 1
48000E1B 0 1B 00000000 1
64001601 0 01 00000000 1
5000021C 1 1C 00060509 0
5000121D 1 1D 0005E803 0
// r0 stays zero
1C048C00 1 00 00000123 0
0000001E 1 1E 00000000 0
0C00041F 1 1F 00000005 0

// File: build.f
rtl/core_pkg.sv
rtl/mem_pkg.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/alu.sv
rtl/execute_stage.sv
rtl/result_stage.sv
rtl/pipe_top.sv
bench/tb_pipe.sv

// File: Bender.yml
package:
  name: pipe_slice

sources:
  - files:
      - rtl/core_pkg.sv
      - rtl/mem_pkg.sv
      - rtl/regfile.sv
      - rtl/decode_stage.sv
      - rtl/alu.sv
      - rtl/execute_stage.sv
      - rtl/result_stage.sv
      - rtl/pipe_top.sv
  - target: simulation
    files:
      - bench/tb_pipe.sv

// File: bench/tb_pipe.sv
`timescale 1ns/1ps

module tb_pipe;

    localparam int COLS       = 5;
    localparam int MAX_ROWS   = 64;
    localparam int WAIT_LIMIT = 200;
    localparam int MEM_WORDS  = 256;
    localparam logic [31:0] PC_BASE = 32'h0000_1000;

    logic        clk;
    logic        resetn;
    logic        inst_valid;
    logic [31:0] inst;
    logic [31:0] inst_pc;
    logic        inst_allowin;
    logic        data_sram_en;
    logic [3:0]  data_sram_we;
    logic [31:0] data_sram_addr;
    logic [31:0] data_sram_wdata;
    logic [31:0] data_sram_rdata;
    logic        commit_valid;
    logic [31:0] commit_pc;
    logic        commit_we;
    logic [4:0]  commit_rd;
    logic [31:0] commit_wdata;
    logic        commit_ale;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] td [MAX_ROWS*COLS];

    int n_rows;
    int n_commits;
    int n_mismatch;
    int n_other;
    bit timed_out;

    pipe_top u_pipe_top (
        .clk             (clk),
        .resetn          (resetn),
        .inst_valid      (inst_valid),
        .inst            (inst),
        .inst_pc         (inst_pc),
        .inst_allowin    (inst_allowin),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata),
        .data_sram_rdata (data_sram_rdata),
        .commit_valid    (commit_valid),
        .commit_pc       (commit_pc),
        .commit_we       (commit_we),
        .commit_rd       (commit_rd),
        .commit_wdata    (commit_wdata),
        .commit_ale      (commit_ale)
    );

    always #5 clk = ~clk;

    // synchronous read, byte-lane write
    always @(posedge clk) begin
        if (data_sram_en) begin
            data_sram_rdata <= mem[data_sram_addr[9:2]];
            for (int b = 0; b < 4; b++) begin
                if (data_sram_we[b]) begin
                    mem[data_sram_addr[9:2]][8*b +: 8] <= data_sram_wdata[8*b +: 8];
                end
            end
        end
    end

    task automatic compare_commit(input int row);
        logic [31:0] exp_pc;
        logic        exp_we;
        logic [4:0]  exp_rd;
        logic [31:0] exp_wdata;
        logic        exp_ale;
        exp_pc    = PC_BASE + 32'(4 * row);
        exp_we    = td[COLS*row + 1][0];
        exp_rd    = td[COLS*row + 2][4:0];
        exp_wdata = td[COLS*row + 3];
        exp_ale   = td[COLS*row + 4][0];
        if (commit_pc !== exp_pc) begin
            $display("mismatch commit_pc row %0d: expected %h actual %h", row, exp_pc, commit_pc);
            n_mismatch++;
        end
        if (commit_we !== exp_we) begin
            $display("mismatch commit_we row %0d: expected %h actual %h", row, exp_we, commit_we);
            n_mismatch++;
        end
        if (commit_rd !== exp_rd) begin
            $display("mismatch commit_rd row %0d: expected %h actual %h", row, exp_rd, commit_rd);
            n_mismatch++;
        end
        if (exp_we && commit_wdata !== exp_wdata) begin
            $display("mismatch commit_wdata row %0d: expected %h actual %h",
                     row, exp_wdata, commit_wdata);
            n_mismatch++;
        end
        if (commit_ale !== exp_ale) begin
            $display("mismatch commit_ale row %0d: expected %h actual %h",
                     row, exp_ale, commit_ale);
            n_mismatch++;
        end
    endtask

    // commits must come back in program order
    always @(posedge clk) begin
        if (resetn && commit_valid) begin
            if (n_commits >= n_rows) begin
                $display("unexpected extra commit at pc %h", commit_pc);
                n_other++;
            end else begin
                compare_commit(n_commits);
            end
            n_commits++;
        end
    end

    // called on a rising edge; returns on the edge that accepts the row
    task automatic drive_instruction(input int row);
        int waited;
        waited = 0;
        inst       <= td[COLS*row];
        inst_pc    <= PC_BASE + 32'(4 * row);
        inst_valid <= 1'b1;
        @(posedge clk);
        while (!inst_allowin && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (!inst_allowin) begin
            $display("timeout: instruction at row %0d was never accepted", row);
            n_other++;
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_for_drain();
        int waited;
        waited = 0;
        while (n_commits < n_rows && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (n_commits < n_rows) begin
            $display("timeout: only %0d of %0d instructions committed", n_commits, n_rows);
            n_other++;
            timed_out = 1'b1;
        end
    endtask

    initial begin
        clk             = 1'b0;
        resetn          = 1'b0;
        inst_valid      = 1'b0;
        inst            = '0;
        inst_pc         = '0;
        data_sram_rdata = '0;
        n_rows          = 0;
        n_commits       = 0;
        n_mismatch      = 0;
        n_other         = 0;
        timed_out       = 1'b0;

        // every byte of a word derived from its full index
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = {~i[7:0], i[7:0], 8'h5a ^ i[7:0], 8'h3c + i[7:0]};
        end

        // all-ones word marks the end of the rows
        for (int i = 0; i < MAX_ROWS*COLS; i++) begin
            td[i] = '1;
        end
        $readmemh("bench/pipe_testdata.txt", td);
        while (n_rows < MAX_ROWS && td[COLS*n_rows] != '1) begin
            n_rows++;
        end
        if (n_rows == 0) begin
            $display("no test rows could be read from the data file");
            n_other++;
        end

        repeat (3) @(posedge clk);
        resetn <= 1'b1;

        for (int r = 0; r < n_rows && !timed_out; r++) begin
            drive_instruction(r);
        end
        inst_valid <= 1'b0;

        if (!timed_out) begin
            wait_for_drain();
        end

        $display("errors: %0d mismatches, %0d other, %0d of %0d rows committed",
                 n_mismatch, n_other, n_commits, n_rows);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// File: rtl/pipe_top.sv
`timescale 1ns/1ps

module pipe_top #(
    parameter int MUL_BITS_PER_CYCLE = 2
) (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         inst_valid,
    input  logic [core_pkg::XLEN-1:0]    inst,
    input  logic [core_pkg::XLEN-1:0]    inst_pc,
    output logic                         inst_allowin,
    output logic                         data_sram_en,
    output logic [mem_pkg::BE_W-1:0]     data_sram_we,
    output logic [mem_pkg::SRAM_AW-1:0]  data_sram_addr,
    output logic [mem_pkg::SRAM_DW-1:0]  data_sram_wdata,
    input  logic [mem_pkg::SRAM_DW-1:0]  data_sram_rdata,
    output logic                         commit_valid,
    output logic [core_pkg::XLEN-1:0]    commit_pc,
    output logic                         commit_we,
    output logic [core_pkg::RADDR_W-1:0] commit_rd,
    output logic [core_pkg::XLEN-1:0]    commit_wdata,
    output logic                         commit_ale
);

    logic [core_pkg::RADDR_W-1:0] rf_raddr1;
    logic [core_pkg::RADDR_W-1:0] rf_raddr2;
    logic [core_pkg::XLEN-1:0]    rf_rdata1;
    logic [core_pkg::XLEN-1:0]    rf_rdata2;
    logic                         rf_we;
    logic [core_pkg::RADDR_W-1:0] rf_waddr;
    logic [core_pkg::XLEN-1:0]    rf_wdata;

    // decode to execute
    logic                         ds2es_valid;
    logic                         es_allowin;
    core_pkg::op_e                ds_op;
    logic [core_pkg::XLEN-1:0]    ds_src1;
    logic [core_pkg::XLEN-1:0]    ds_src2;
    logic [core_pkg::XLEN-1:0]    ds_rkd_value;
    logic [core_pkg::RADDR_W-1:0] ds_rd;
    logic                         ds_rf_we;
    logic [core_pkg::XLEN-1:0]    ds_pc;

    // execute to result, plus hazard taps
    logic                         es2rs_valid;
    logic                         rs_allowin;
    core_pkg::op_e                es_op;
    logic [core_pkg::XLEN-1:0]    es_alu_result;
    logic [core_pkg::RADDR_W-1:0] es_rd;
    logic                         es_ale;
    logic [core_pkg::XLEN-1:0]    es_pc;
    logic                         es_rf_we;
    logic [core_pkg::RADDR_W-1:0] es_rf_waddr;
    logic                         rs_rf_we;
    logic [core_pkg::RADDR_W-1:0] rs_rf_waddr;

    regfile u_regfile (
        .clk    (clk),
        .raddr1 (rf_raddr1),
        .raddr2 (rf_raddr2),
        .waddr  (rf_waddr),
        .we     (rf_we),
        .wdata  (rf_wdata),
        .rdata1 (rf_rdata1),
        .rdata2 (rf_rdata2)
    );

    decode_stage u_decode_stage (
        .clk          (clk),
        .resetn       (resetn),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .inst_pc      (inst_pc),
        .inst_allowin (inst_allowin),
        .rf_raddr1    (rf_raddr1),
        .rf_raddr2    (rf_raddr2),
        .rf_rdata1    (rf_rdata1),
        .rf_rdata2    (rf_rdata2),
        .es_rf_we     (es_rf_we),
        .es_rf_waddr  (es_rf_waddr),
        .rs_rf_we     (rs_rf_we),
        .rs_rf_waddr  (rs_rf_waddr),
        .es_allowin   (es_allowin),
        .ds2es_valid  (ds2es_valid),
        .ds_op        (ds_op),
        .ds_src1      (ds_src1),
        .ds_src2      (ds_src2),
        .ds_rkd_value (ds_rkd_value),
        .ds_rd        (ds_rd),
        .ds_rf_we     (ds_rf_we),
        .ds_pc        (ds_pc)
    );

    execute_stage #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) u_execute_stage (
        .clk             (clk),
        .resetn          (resetn),
        .ds2es_valid     (ds2es_valid),
        .ds_op           (ds_op),
        .ds_src1         (ds_src1),
        .ds_src2         (ds_src2),
        .ds_rkd_value    (ds_rkd_value),
        .ds_rd           (ds_rd),
        .ds_rf_we        (ds_rf_we),
        .ds_pc           (ds_pc),
        .es_allowin      (es_allowin),
        .rs_allowin      (rs_allowin),
        .es2rs_valid     (es2rs_valid),
        .es_op           (es_op),
        .es_alu_result   (es_alu_result),
        .es_rd           (es_rd),
        .es_ale          (es_ale),
        .es_pc           (es_pc),
        .es_rf_we        (es_rf_we),
        .es_rf_waddr     (es_rf_waddr),
        .data_sram_en    (data_sram_en),
        .data_sram_we    (data_sram_we),
        .data_sram_addr  (data_sram_addr),
        .data_sram_wdata (data_sram_wdata)
    );

    result_stage u_result_stage (
        .clk             (clk),
        .resetn          (resetn),
        .es2rs_valid     (es2rs_valid),
        .es_op           (es_op),
        .es_alu_result   (es_alu_result),
        .es_rd           (es_rd),
        .es_rf_we        (es_rf_we),
        .es_ale          (es_ale),
        .es_pc           (es_pc),
        .rs_allowin      (rs_allowin),
        .data_sram_rdata (data_sram_rdata),
        .rs_rf_we        (rs_rf_we),
        .rs_rf_waddr     (rs_rf_waddr),
        .rf_we           (rf_we),
        .rf_waddr        (rf_waddr),
        .rf_wdata        (rf_wdata),
        .commit_valid    (commit_valid),
        .commit_pc       (commit_pc),
        .commit_we       (commit_we),
        .commit_rd       (commit_rd),
        .commit_wdata    (commit_wdata),
        .commit_ale      (commit_ale)
    );

endmodule

// File: rtl/result_stage.sv
`timescale 1ns/1ps

module result_stage (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         es2rs_valid,
    input  core_pkg::op_e                es_op,
    input  logic [core_pkg::XLEN-1:0]    es_alu_result,
    input  logic [core_pkg::RADDR_W-1:0] es_rd,
    input  logic                         es_rf_we,
    input  logic                         es_ale,
    input  logic [core_pkg::XLEN-1:0]    es_pc,
    output logic                         rs_allowin,
    input  logic [mem_pkg::SRAM_DW-1:0]  data_sram_rdata,
    output logic                         rs_rf_we,
    output logic [core_pkg::RADDR_W-1:0] rs_rf_waddr,
    output logic                         rf_we,
    output logic [core_pkg::RADDR_W-1:0] rf_waddr,
    output logic [core_pkg::XLEN-1:0]    rf_wdata,
    output logic                         commit_valid,
    output logic [core_pkg::XLEN-1:0]    commit_pc,
    output logic                         commit_we,
    output logic [core_pkg::RADDR_W-1:0] commit_rd,
    output logic [core_pkg::XLEN-1:0]    commit_wdata,
    output logic                         commit_ale
);

    logic                         rs_valid;
    logic                         rs_ready_go;
    core_pkg::op_e                rs_op;
    logic [core_pkg::XLEN-1:0]    rs_alu_result;
    logic [core_pkg::RADDR_W-1:0] rs_rd;
    logic                         rs_rf_we_r;
    logic                         rs_ale;
    logic [core_pkg::XLEN-1:0]    rs_pc;
    logic [7:0]                   ld_byte;
    logic [15:0]                  ld_half;
    logic [core_pkg::XLEN-1:0]    rs_final;

    // last stage, nothing downstream to wait on
    assign rs_ready_go = 1'b1;
    assign rs_allowin  = !rs_valid || rs_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            rs_valid <= 1'b0;
        end else if (rs_allowin) begin
            rs_valid <= es2rs_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (es2rs_valid && rs_allowin) begin
            rs_op         <= es_op;
            rs_alu_result <= es_alu_result;
            rs_rd         <= es_rd;
            rs_rf_we_r    <= es_rf_we;
            rs_ale        <= es_ale;
            rs_pc         <= es_pc;
        end
    end

    // sram word arrives this cycle; pick the lane by address
    assign ld_byte = data_sram_rdata[8*rs_alu_result[1:0] +: 8];
    assign ld_half = rs_alu_result[1] ? data_sram_rdata[31:16] : data_sram_rdata[15:0];

    always_comb begin
        case (rs_op)
            core_pkg::op_ld_b:  rs_final = {{(core_pkg::XLEN - 8){ld_byte[7]}}, ld_byte};
            core_pkg::op_ld_bu: rs_final = {{(core_pkg::XLEN - 8){1'b0}}, ld_byte};
            core_pkg::op_ld_h:  rs_final = {{(core_pkg::XLEN - 16){ld_half[15]}}, ld_half};
            core_pkg::op_ld_hu: rs_final = {{(core_pkg::XLEN - 16){1'b0}}, ld_half};
            core_pkg::op_ld_w:  rs_final = data_sram_rdata;
            default:            rs_final = rs_alu_result;
        endcase
    end

    assign rf_we       = rs_valid && rs_rf_we_r;
    assign rf_waddr    = rs_rd;
    assign rf_wdata    = rs_final;
    assign rs_rf_we    = rf_we;
    assign rs_rf_waddr = rs_rd;

    assign commit_valid = rs_valid;
    assign commit_pc    = rs_pc;
    assign commit_we    = rf_we;
    assign commit_rd    = rs_rd;
    assign commit_wdata = rs_final;
    assign commit_ale   = rs_ale;

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
    parameter int MUL_BITS_PER_CYCLE = 2
) (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         ds2es_valid,
    input  core_pkg::op_e                ds_op,
    input  logic [core_pkg::XLEN-1:0]    ds_src1,
    input  logic [core_pkg::XLEN-1:0]    ds_src2,
    input  logic [core_pkg::XLEN-1:0]    ds_rkd_value,
    input  logic [core_pkg::RADDR_W-1:0] ds_rd,
    input  logic                         ds_rf_we,
    input  logic [core_pkg::XLEN-1:0]    ds_pc,
    output logic                         es_allowin,
    input  logic                         rs_allowin,
    output logic                         es2rs_valid,
    output core_pkg::op_e                es_op,
    output logic [core_pkg::XLEN-1:0]    es_alu_result,
    output logic [core_pkg::RADDR_W-1:0] es_rd,
    output logic                         es_ale,
    output logic [core_pkg::XLEN-1:0]    es_pc,
    output logic                         es_rf_we,
    output logic [core_pkg::RADDR_W-1:0] es_rf_waddr,
    output logic                         data_sram_en,
    output logic [mem_pkg::BE_W-1:0]     data_sram_we,
    output logic [mem_pkg::SRAM_AW-1:0]  data_sram_addr,
    output logic [mem_pkg::SRAM_DW-1:0]  data_sram_wdata
);

    logic                      es_valid;
    logic                      es_ready_go;
    logic [core_pkg::XLEN-1:0] es_src1;
    logic [core_pkg::XLEN-1:0] es_src2;
    logic [core_pkg::XLEN-1:0] es_rkd_value;
    logic                      es_rf_we_r;
    logic                      is_load;
    logic                      is_store;
    mem_pkg::size_e            mem_size;
    logic [mem_pkg::BE_W-1:0]  byte_en;

    assign es_allowin  = !es_valid || (es_ready_go && rs_allowin);
    assign es2rs_valid = es_valid && es_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            es_valid <= 1'b0;
        end else if (es_allowin) begin
            es_valid <= ds2es_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (ds2es_valid && es_allowin) begin
            es_op        <= ds_op;
            es_src1      <= ds_src1;
            es_src2      <= ds_src2;
            es_rkd_value <= ds_rkd_value;
            es_rd        <= ds_rd;
            es_rf_we_r   <= ds_rf_we;
            es_pc        <= ds_pc;
        end
    end

    alu #(
        .MUL_BITS_PER_CYCLE (MUL_BITS_PER_CYCLE)
    ) u_alu (
        .clk      (clk),
        .resetn   (resetn),
        .start    (es_valid),
        .op       (es_op),
        .src1     (es_src1),
        .src2     (es_src2),
        .result   (es_alu_result),
        .complete (es_ready_go)
    );

    assign is_load  = es_op inside {core_pkg::op_ld_b, core_pkg::op_ld_bu, core_pkg::op_ld_h,
                                    core_pkg::op_ld_hu, core_pkg::op_ld_w};
    assign is_store = es_op inside {core_pkg::op_st_b, core_pkg::op_st_h, core_pkg::op_st_w};

    always_comb begin
        case (es_op)
            core_pkg::op_ld_b, core_pkg::op_ld_bu, core_pkg::op_st_b: mem_size = mem_pkg::size_b;
            core_pkg::op_ld_h, core_pkg::op_ld_hu, core_pkg::op_st_h: mem_size = mem_pkg::size_h;
            default: mem_size = mem_pkg::size_w;
        endcase
    end

    // misaligned word or halfword
    assign es_ale = (is_load || is_store) &&
                    ((mem_size == mem_pkg::size_w && es_alu_result[1:0] != 2'b00) ||
                     (mem_size == mem_pkg::size_h && es_alu_result[0]));

    assign es_rf_we    = es_valid && es_rf_we_r && !es_ale;
    assign es_rf_waddr = es_rd;

    // lanes and replicated store data
    always_comb begin
        case (mem_size)
            mem_pkg::size_b: begin
                byte_en         = mem_pkg::BE_W'(1) << es_alu_result[1:0];
                data_sram_wdata = {4{es_rkd_value[7:0]}};
            end
            mem_pkg::size_h: begin
                byte_en         = es_alu_result[1] ? 4'b1100 : 4'b0011;
                data_sram_wdata = {2{es_rkd_value[15:0]}};
            end
            default: begin
                byte_en         = 4'b1111;
                data_sram_wdata = es_rkd_value;
            end
        endcase
    end

    // only in the cycle the item leaves, so a store lands once
    assign data_sram_en   = es_valid && es_ready_go && rs_allowin &&
                            (is_load || is_store) && !es_ale;
    assign data_sram_we   = {mem_pkg::BE_W{data_sram_en && is_store}} & byte_en;
    assign data_sram_addr = {es_alu_result[mem_pkg::SRAM_AW-1:2], 2'b00};

endmodule

// File: rtl/alu.sv
`timescale 1ns/1ps

module alu #(
    parameter int MUL_BITS_PER_CYCLE = 2
) (
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      start,
    input  core_pkg::op_e             op,
    input  logic [core_pkg::XLEN-1:0] src1,
    input  logic [core_pkg::XLEN-1:0] src2,
    output logic [core_pkg::XLEN-1:0] result,
    output logic                      complete
);

    localparam int MUL_CYCLES = core_pkg::XLEN / MUL_BITS_PER_CYCLE;
    localparam int CNT_W      = $clog2(MUL_CYCLES);

    typedef enum logic {st_idle, st_busy} state_e;

    state_e                    state;
    logic [CNT_W-1:0]          count;
    logic [core_pkg::XLEN-1:0] mcand;
    logic [core_pkg::XLEN-1:0] mplier;
    logic [core_pkg::XLEN-1:0] acc;
    logic [core_pkg::XLEN-1:0] pp_cand;
    logic [core_pkg::XLEN-1:0] pp_plier;
    logic [core_pkg::XLEN-1:0] partial;
    logic [core_pkg::XLEN-1:0] product;

    // first step runs straight off the operands in the start cycle
    assign pp_cand  = (state == st_busy) ? mcand : src1;
    assign pp_plier = (state == st_busy) ? mplier : src2;

    always_comb begin
        partial = '0;
        for (int i = 0; i < MUL_BITS_PER_CYCLE; i++) begin
            if (pp_plier[i]) begin
                partial = partial + (pp_cand << i);
            end
        end
    end

    assign product = acc + partial;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= st_idle;
            count <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start && op == core_pkg::op_mul) begin
                        state <= st_busy;
                        count <= CNT_W'(1);
                    end
                end
                st_busy: begin
                    count <= count + CNT_W'(1);
                    if (complete) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        acc    <= ((state == st_busy) ? acc : '0) + partial;
        mcand  <= pp_cand << MUL_BITS_PER_CYCLE;
        mplier <= pp_plier >> MUL_BITS_PER_CYCLE;
    end

    assign complete = (op == core_pkg::op_mul) ?
                      (state == st_busy && count == CNT_W'(MUL_CYCLES - 1)) : start;

    always_comb begin
        case (op)
            core_pkg::op_sub:  result = src1 - src2;
            core_pkg::op_and:  result = src1 & src2;
            core_pkg::op_or:   result = src1 | src2;
            core_pkg::op_xor:  result = src1 ^ src2;
            core_pkg::op_sltu: result = {{(core_pkg::XLEN - 1){1'b0}}, src1 < src2};
            core_pkg::op_slli: result = src1 << src2[4:0];
            core_pkg::op_mul:  result = product;
            // add, addi and load/store address
            default:           result = src1 + src2;
        endcase
    end

    a_mul_latency : assert property (@(posedge clk) disable iff (!resetn)
        (state == st_idle && start && op == core_pkg::op_mul) |-> ##(MUL_CYCLES - 1) complete);

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                         clk,
    input  logic                         resetn,
    input  logic                         inst_valid,
    input  logic [core_pkg::XLEN-1:0]    inst,
    input  logic [core_pkg::XLEN-1:0]    inst_pc,
    output logic                         inst_allowin,
    output logic [core_pkg::RADDR_W-1:0] rf_raddr1,
    output logic [core_pkg::RADDR_W-1:0] rf_raddr2,
    input  logic [core_pkg::XLEN-1:0]    rf_rdata1,
    input  logic [core_pkg::XLEN-1:0]    rf_rdata2,
    input  logic                         es_rf_we,
    input  logic [core_pkg::RADDR_W-1:0] es_rf_waddr,
    input  logic                         rs_rf_we,
    input  logic [core_pkg::RADDR_W-1:0] rs_rf_waddr,
    input  logic                         es_allowin,
    output logic                         ds2es_valid,
    output core_pkg::op_e                ds_op,
    output logic [core_pkg::XLEN-1:0]    ds_src1,
    output logic [core_pkg::XLEN-1:0]    ds_src2,
    output logic [core_pkg::XLEN-1:0]    ds_rkd_value,
    output logic [core_pkg::RADDR_W-1:0] ds_rd,
    output logic                         ds_rf_we,
    output logic [core_pkg::XLEN-1:0]    ds_pc
);

    logic                         ds_valid;
    logic                         ds_ready_go;
    logic [core_pkg::XLEN-1:0]    ds_inst;
    logic [core_pkg::RADDR_W-1:0] rj;
    logic [core_pkg::RADDR_W-1:0] rk;
    logic [core_pkg::XLEN-1:0]    imm;
    logic                         use_imm;
    logic                         is_store;

    // write still in flight to a nonzero register
    function automatic logic pending(input logic [core_pkg::RADDR_W-1:0] r);
        return (r != '0) &&
               ((es_rf_we && es_rf_waddr == r) || (rs_rf_we && rs_rf_waddr == r));
    endfunction

    assign inst_allowin = !ds_valid || (ds_ready_go && es_allowin);
    assign ds2es_valid  = ds_valid && ds_ready_go;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ds_valid <= 1'b0;
        end else if (inst_allowin) begin
            ds_valid <= inst_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_valid && inst_allowin) begin
            ds_inst <= inst;
            ds_pc   <= inst_pc;
        end
    end

    // field decode
    assign ds_op    = core_pkg::op_e'(ds_inst[core_pkg::OP_HI:core_pkg::OP_LO]);
    assign rj       = ds_inst[core_pkg::RJ_HI:core_pkg::RJ_LO];
    assign rk       = ds_inst[core_pkg::RK_HI:core_pkg::RK_LO];
    assign ds_rd    = ds_inst[core_pkg::RD_HI:core_pkg::RD_LO];
    assign imm      = {{(core_pkg::XLEN - core_pkg::IMM_W){ds_inst[core_pkg::IMM_HI]}},
                       ds_inst[core_pkg::IMM_HI:core_pkg::IMM_LO]};
    assign use_imm  = !(ds_op inside {core_pkg::op_add, core_pkg::op_sub, core_pkg::op_and,
                                      core_pkg::op_or, core_pkg::op_xor, core_pkg::op_sltu,
                                      core_pkg::op_mul});
    assign is_store = ds_op inside {core_pkg::op_st_b, core_pkg::op_st_h, core_pkg::op_st_w};
    assign ds_rf_we = !is_store;

    // stores read rd as the data operand
    assign rf_raddr1    = rj;
    assign rf_raddr2    = is_store ? ds_rd : rk;
    assign ds_src1      = rf_rdata1;
    assign ds_src2      = use_imm ? imm : rf_rdata2;
    assign ds_rkd_value = rf_rdata2;

    always_comb begin
        ds_ready_go = !(pending(rj) || (!use_imm && pending(rk)) ||
                        (is_store && pending(ds_rd)));
    end

endmodule

// File: rtl/regfile.sv
`timescale 1ns/1ps

module regfile (
    input  logic                         clk,
    input  logic [core_pkg::RADDR_W-1:0] raddr1,
    input  logic [core_pkg::RADDR_W-1:0] raddr2,
    input  logic [core_pkg::RADDR_W-1:0] waddr,
    input  logic                         we,
    input  logic [core_pkg::XLEN-1:0]    wdata,
    output logic [core_pkg::XLEN-1:0]    rdata1,
    output logic [core_pkg::XLEN-1:0]    rdata2
);

    logic [core_pkg::XLEN-1:0] regs [core_pkg::NREG];

    // r0 is never stored
    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    // a nonzero register reads back the last value written to it
    a_write_read : assert property (@(posedge clk)
        (we && waddr != '0) |=> (raddr1 != $past(waddr) || rdata1 == $past(wdata)));

endmodule

// File: rtl/mem_pkg.sv
package mem_pkg;

    // data sram port widths
    localparam int SRAM_AW = 32;
    localparam int SRAM_DW = 32;
    localparam int BE_W    = SRAM_DW / 8;

    // access size of a load or store
    typedef enum logic [1:0] {
        size_b = 2'd0,
        size_h = 2'd1,
        size_w = 2'd2
    } size_e;

endpackage

// File: rtl/core_pkg.sv
package core_pkg;

    localparam int XLEN    = 32;
    localparam int NREG    = 32;
    localparam int RADDR_W = 5;
    localparam int OP_W    = 6;

    // instruction field positions
    localparam int OP_HI  = 31;
    localparam int OP_LO  = 26;
    localparam int RD_HI  = 4;
    localparam int RD_LO  = 0;
    localparam int RJ_HI  = 9;
    localparam int RJ_LO  = 5;
    localparam int RK_HI  = 14;
    localparam int RK_LO  = 10;
    localparam int IMM_HI = 21;
    localparam int IMM_LO = 10;
    localparam int IMM_W  = IMM_HI - IMM_LO + 1;

    // reg-reg group first, then immediates, mul, loads, stores
    typedef enum logic [OP_W-1:0] {
        op_add   = 6'h00, op_sub   = 6'h01, op_and   = 6'h02, op_or    = 6'h03,
        op_xor   = 6'h04, op_sltu  = 6'h05, op_slli  = 6'h06, op_addi  = 6'h07,
        op_mul   = 6'h08,
        op_ld_b  = 6'h10, op_ld_bu = 6'h11, op_ld_h  = 6'h12, op_ld_hu = 6'h13,
        op_ld_w  = 6'h14,
        op_st_b  = 6'h18, op_st_h  = 6'h19, op_st_w  = 6'h1a
    } op_e;

endpackage
